// ==== Bender.yml ====
package:
  name: data_periph_demux

sources:
  - common/demux_pkg.sv
  - src/data_addr_decoder.sv
  - src/req_router.sv
  - src/resp_mux.sv
  - periph_bridge/periph_bridge.sv
  - src/data_periph_demux.sv
  - target: test
    files:
      - testbench/data_periph_demux_chk.sv
      - testbench/tb_data_periph_demux.sv

// ==== common/demux_pkg.sv ====
// Data demux shared types
`default_nettype none

package demux_pkg;

  // ******************************
  // Widths
  // ******************************
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned BE_W       = DATA_W / 8;
  localparam int unsigned NIBBLE_W   = 4;
  localparam int unsigned REGION_W   = 12;
  localparam int unsigned CLUSTER_W  = 6;
  localparam int unsigned NIBBLE_LSB = ADDR_W - NIBBLE_W;   // Top nibble starts at bit 28
  localparam int unsigned REGION_LSB = ADDR_W - REGION_W;   // 1 MiB regions start at bit 20

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [BE_W-1:0]      be_t;
  typedef logic [NIBBLE_W-1:0]  nibble_t;
  typedef logic [REGION_W-1:0]  region_t;
  typedef logic [CLUSTER_W-1:0] cluster_id_t;

  // ******************************
  // Enums
  // ******************************
  typedef enum logic [1:0] {
    SH  = 2'd0,   // Shared TCDM interconnect
    PE  = 2'd1,   // Peripheral interconnect
    EXT = 2'd2    // Demux peripherals
  } dest_e;

  typedef enum logic [1:0] {
    PE_IDLE    = 2'd0,
    PE_PENDING = 2'd1,
    PE_GRANTED = 2'd2
  } pe_state_e;

  // ******************************
  // Request and response
  // ******************************
  typedef struct packed {
    addr_t addr;
    logic  wen;     // High for a load
    data_t wdata;
    be_t   be;
  } req_t;

  typedef struct packed {
    logic  valid;
    data_t rdata;
    logic  opc;     // Error flag
  } rsp_t;

  // Memory map
  localparam region_t     CLUSTER_REGION_BASE = 12'h100;
  localparam int unsigned EXT_SEL_BIT         = 14;   // Splits the demux peripheral region

endpackage : demux_pkg

`default_nettype wire

// ==== list.f ====
common/demux_pkg.sv
src/data_addr_decoder.sv
src/req_router.sv
src/resp_mux.sv
periph_bridge/periph_bridge.sv
src/data_periph_demux.sv
testbench/data_periph_demux_chk.sv
testbench/tb_data_periph_demux.sv

// ==== periph_bridge/periph_bridge.sv ====
// Peripheral interconnect bridge
`timescale 1ns/1ps
`default_nettype none

module periph_bridge (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic            req_i,
  output logic            pe_req_o,
  input  logic            pe_gnt_i,
  input  demux_pkg::rsp_t pe_rsp_i,
  output logic            core_gnt_o,
  output demux_pkg::rsp_t core_rsp_o
);

  import demux_pkg::*;

  localparam int unsigned STAGES = 2;

  pe_state_e state_q;
  pe_state_e state_d;

  logic [STAGES-1:0] vld_q;
  data_t             rdata_q [STAGES];
  logic              opc_q   [STAGES];
  rsp_t              stage_in [STAGES];

  // ******************************
  // Transaction FSM
  // ******************************
  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= PE_IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d    = state_q;
    pe_req_o   = 1'b0;
    core_gnt_o = 1'b0;
    case (state_q)
      PE_IDLE:
      begin
        pe_req_o = req_i;
        if (req_i && pe_gnt_i)
          state_d = PE_PENDING;
      end
      PE_PENDING:
      begin
        if (pe_rsp_i.valid)
          state_d = PE_GRANTED;   // Core is granted one cycle later
      end
      PE_GRANTED:
      begin
        core_gnt_o = 1'b1;
        state_d    = PE_IDLE;
      end
      default: state_d = PE_IDLE;
    endcase
  end

  // ******************************
  // Response delay line
  // ******************************
  assign stage_in[0] = pe_rsp_i;
  assign stage_in[1] = '{valid: vld_q[0], rdata: rdata_q[0], opc: opc_q[0]};

  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
      vld_q <= '0;
    else
      vld_q <= {stage_in[1].valid, stage_in[0].valid};
  end

  // Payload only moves with a valid response
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < STAGES; i++)
    begin
      if (stage_in[i].valid)
      begin
        rdata_q[i] <= stage_in[i].rdata;
        opc_q[i]   <= stage_in[i].opc;
      end
    end
  end

  assign core_rsp_o = '{valid: vld_q[STAGES-1], rdata: rdata_q[STAGES-1], opc: opc_q[STAGES-1]};

endmodule : periph_bridge

`default_nettype wire

// ==== src/data_addr_decoder.sv ====
// Address remap and decode
`timescale 1ns/1ps
`default_nettype none

module data_addr_decoder #(
  parameter bit                 REMAP_ADDRESS      = 1'b0,
  parameter bit                 CLUSTER_ALIAS      = 1'b1,
  parameter demux_pkg::region_t CLUSTER_ALIAS_BASE = 12'h000
) (
  input  demux_pkg::req_t        core_req_data_i,
  input  demux_pkg::nibble_t     base_addr_i,
  input  demux_pkg::cluster_id_t cluster_id_i,
  output demux_pkg::req_t        out_req_o,
  output demux_pkg::dest_e       dest_o
);

  import demux_pkg::*;

  localparam region_t ALIAS_TS  = CLUSTER_ALIAS_BASE + 12'd1;
  localparam region_t ALIAS_PER = CLUSTER_ALIAS_BASE + 12'd2;

  nibble_t in_nibble;
  nibble_t out_nibble;
  region_t region;
  region_t tcdm_rw;
  region_t tcdm_ts;
  region_t dem_per;
  logic    hit_tcdm;
  logic    hit_dem_per;

  // ******************************
  // Top nibble remap
  // ******************************
  assign in_nibble = core_req_data_i.addr[ADDR_W-1:NIBBLE_LSB];

  always_comb
  begin
    out_nibble = in_nibble;
    if (REMAP_ADDRESS)
    begin
      if (in_nibble == base_addr_i)
        out_nibble = nibble_t'(1);
      else if (in_nibble == nibble_t'(1))
        out_nibble = base_addr_i;
    end
  end

  always_comb
  begin
    out_req_o      = core_req_data_i;   // wen, wdata and be pass through
    out_req_o.addr = {out_nibble, core_req_data_i.addr[NIBBLE_LSB-1:0]};
  end

  // ******************************
  // Region decode
  // ******************************
  assign region  = out_req_o.addr[ADDR_W-1:REGION_LSB];

  // Each cluster owns four consecutive regions
  assign tcdm_rw = CLUSTER_REGION_BASE + (region_t'(cluster_id_i) << 2);
  assign tcdm_ts = tcdm_rw + 12'd1;
  assign dem_per = tcdm_rw + 12'd2;

  assign hit_tcdm = (region == tcdm_rw) || (region == tcdm_ts) ||
                    (CLUSTER_ALIAS && ((region == CLUSTER_ALIAS_BASE) || (region == ALIAS_TS)));

  assign hit_dem_per = (region == dem_per) || (CLUSTER_ALIAS && (region == ALIAS_PER));

  always_comb
  begin
    if (hit_tcdm)
      dest_o = SH;
    else if (hit_dem_per)
      dest_o = out_req_o.addr[EXT_SEL_BIT] ? EXT : PE;
    else
      dest_o = PE;   // Cluster peripherals and everything beyond
  end

endmodule : data_addr_decoder

`default_nettype wire

// ==== src/data_periph_demux.sv ====
// Core data demultiplexer
`timescale 1ns/1ps
`default_nettype none

module data_periph_demux #(
  parameter bit                 REMAP_ADDRESS      = 1'b0,
  parameter bit                 CLUSTER_ALIAS      = 1'b1,
  parameter demux_pkg::region_t CLUSTER_ALIAS_BASE = 12'h000
) (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  demux_pkg::nibble_t     base_addr_i,
  input  demux_pkg::cluster_id_t cluster_id_i,

  // Core side
  input  logic                   core_req_i,
  input  demux_pkg::req_t        core_req_data_i,
  output logic                   core_gnt_o,
  output demux_pkg::rsp_t        core_rsp_o,

  // Payload shared by all targets
  output demux_pkg::req_t        out_req_o,

  // Shared TCDM interconnect
  output logic                   sh_req_o,
  input  logic                   sh_gnt_i,
  input  logic                   sh_r_valid_i,
  input  demux_pkg::data_t       sh_r_rdata_i,

  // Demux peripherals
  output logic                   ext_req_o,
  input  logic                   ext_gnt_i,
  input  demux_pkg::rsp_t        ext_rsp_i,

  // Peripheral interconnect
  output logic                   pe_req_o,
  input  logic                   pe_gnt_i,
  input  demux_pkg::rsp_t        pe_rsp_i,

  // L2 performance strobes
  output logic                   perf_l2_ld_o,
  output logic                   perf_l2_st_o,
  output logic                   perf_l2_ld_cyc_o,
  output logic                   perf_l2_st_cyc_o
);

  import demux_pkg::*;

  dest_e dest;
  logic  bridge_req;    // Router to bridge
  logic  bridge_gnt;    // Bridge grant back to the core
  rsp_t  bridge_rsp;    // Delayed PE response

  data_addr_decoder #(
    .REMAP_ADDRESS      (REMAP_ADDRESS),
    .CLUSTER_ALIAS      (CLUSTER_ALIAS),
    .CLUSTER_ALIAS_BASE (CLUSTER_ALIAS_BASE)
  ) u_decoder (
    .core_req_data_i (core_req_data_i),
    .base_addr_i     (base_addr_i),
    .cluster_id_i    (cluster_id_i),
    .out_req_o       (out_req_o),
    .dest_o          (dest)
  );

  req_router u_router (
    .core_req_i       (core_req_i),
    .dest_i           (dest),
    .wen_i            (out_req_o.wen),
    .sh_gnt_i         (sh_gnt_i),
    .ext_gnt_i        (ext_gnt_i),
    .pe_gnt_i         (bridge_gnt),
    .sh_req_o         (sh_req_o),
    .ext_req_o        (ext_req_o),
    .pe_req_o         (bridge_req),
    .core_gnt_o       (core_gnt_o),
    .perf_l2_ld_o     (perf_l2_ld_o),
    .perf_l2_st_o     (perf_l2_st_o),
    .perf_l2_ld_cyc_o (perf_l2_ld_cyc_o),
    .perf_l2_st_cyc_o (perf_l2_st_cyc_o)
  );

  periph_bridge u_bridge (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .req_i      (bridge_req),
    .pe_req_o   (pe_req_o),
    .pe_gnt_i   (pe_gnt_i),
    .pe_rsp_i   (pe_rsp_i),
    .core_gnt_o (bridge_gnt),
    .core_rsp_o (bridge_rsp)
  );

  resp_mux u_resp (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .core_req_i   (core_req_i),
    .dest_i       (dest),
    .sh_r_valid_i (sh_r_valid_i),
    .sh_r_rdata_i (sh_r_rdata_i),
    .pe_rsp_i     (bridge_rsp),
    .ext_rsp_i    (ext_rsp_i),
    .core_rsp_o   (core_rsp_o)
  );

endmodule : data_periph_demux

`default_nettype wire

// ==== src/req_router.sv ====
// Request router and L2 strobes
`timescale 1ns/1ps
`default_nettype none

module req_router (
  input  logic             core_req_i,
  input  demux_pkg::dest_e dest_i,
  input  logic             wen_i,
  input  logic             sh_gnt_i,
  input  logic             ext_gnt_i,
  input  logic             pe_gnt_i,
  output logic             sh_req_o,
  output logic             ext_req_o,
  output logic             pe_req_o,
  output logic             core_gnt_o,
  output logic             perf_l2_ld_o,
  output logic             perf_l2_st_o,
  output logic             perf_l2_ld_cyc_o,
  output logic             perf_l2_st_cyc_o
);

  import demux_pkg::*;

  logic l2_req;
  logic l2_gnt;

  // ******************************
  // Strobe gating
  // ******************************
  always_comb
  begin
    sh_req_o   = 1'b0;
    ext_req_o  = 1'b0;
    pe_req_o   = 1'b0;
    core_gnt_o = 1'b0;
    case (dest_i)
      SH:
      begin
        sh_req_o   = core_req_i;
        core_gnt_o = sh_gnt_i;
      end
      EXT:
      begin
        ext_req_o  = core_req_i;
        core_gnt_o = ext_gnt_i;
      end
      default:
      begin
        pe_req_o   = core_req_i;   // Bridge handles the PE handshake
        core_gnt_o = pe_gnt_i;
      end
    endcase
  end

  // EXT and PE together form the L2 path
  assign l2_req = ext_req_o | pe_req_o;
  assign l2_gnt = (dest_i == EXT) ? ext_gnt_i : pe_gnt_i;

  // Performance strobes
  assign perf_l2_ld_o     = l2_req & l2_gnt & wen_i;
  assign perf_l2_st_o     = l2_req & l2_gnt & ~wen_i;
  assign perf_l2_ld_cyc_o = l2_req & wen_i;    // Every cycle a load waits or completes
  assign perf_l2_st_cyc_o = l2_req & ~wen_i;

endmodule : req_router

`default_nettype wire

// ==== src/resp_mux.sv ====
// Core response selection
`timescale 1ns/1ps
`default_nettype none

module resp_mux (
  input  logic             clk,
  input  logic             rst_ni,
  input  logic             core_req_i,
  input  demux_pkg::dest_e dest_i,
  input  logic             sh_r_valid_i,
  input  demux_pkg::data_t sh_r_rdata_i,
  input  demux_pkg::rsp_t  pe_rsp_i,
  input  demux_pkg::rsp_t  ext_rsp_i,
  output demux_pkg::rsp_t  core_rsp_o
);

  import demux_pkg::*;

  dest_e dest_q;   // Target of the last request

  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
      dest_q <= SH;
    else if (core_req_i)
      dest_q <= dest_i;
  end

  // ******************************
  // Response select
  // ******************************
  always_comb
  begin
    case (dest_q)
      SH:
      begin
        core_rsp_o.valid = sh_r_valid_i;
        core_rsp_o.rdata = sh_r_rdata_i;
        core_rsp_o.opc   = 1'b0;   // TCDM never reports an error
      end
      PE:      core_rsp_o = pe_rsp_i;
      EXT:     core_rsp_o = ext_rsp_i;
      default: core_rsp_o = '0;
    endcase
  end

endmodule : resp_mux

`default_nettype wire

// ==== testbench/data_periph_demux_chk.sv ====
// Demux port assertions
`timescale 1ns/1ps
`default_nettype none

module data_periph_demux_chk (
  input logic            clk,
  input logic            rst_ni,
  input logic            core_req_i,
  input logic            sh_req_o,
  input logic            ext_req_o,
  input logic            pe_req_o,
  input demux_pkg::rsp_t core_rsp_o
);

  import demux_pkg::*;

  int fail_count = 0;   // Failed assertions so far

  // Only one target sees a request
  one_target: assert property (@(posedge clk) disable iff (!rst_ni)
    $onehot0({sh_req_o, ext_req_o, pe_req_o}))
  else
  begin
    fail_count++;
    $error("More than one target strobe is high");
  end

  strobe_needs_req: assert property (@(posedge clk) disable iff (!rst_ni)
    (sh_req_o || ext_req_o || pe_req_o) |-> core_req_i)
  else
  begin
    fail_count++;
    $error("Target strobe high without a core request");
  end

  quiet_in_reset: assert property (@(posedge clk)
    !rst_ni |-> (!pe_req_o && !core_rsp_o.valid))
  else
  begin
    fail_count++;
    $error("pe_req_o or response valid high during reset");
  end

endmodule : data_periph_demux_chk

bind data_periph_demux data_periph_demux_chk u_chk (
  .clk        (clk),
  .rst_ni     (rst_ni),
  .core_req_i (core_req_i),
  .sh_req_o   (sh_req_o),
  .ext_req_o  (ext_req_o),
  .pe_req_o   (pe_req_o),
  .core_rsp_o (core_rsp_o)
);

`default_nettype wire

// ==== testbench/tb_data_periph_demux.sv ====
// Data demux testbench
`timescale 1ns/1ps
`default_nettype none

module tb_data_periph_demux;

  import demux_pkg::*;

  localparam int unsigned NUM_TESTS       = 5;
  localparam int unsigned CYCLES_PER_TEST = 200;

  logic       clk;
  logic       rst_ni;
  logic       core_req_i;
  req_t       core_req_data_i;
  logic       core_gnt_o;
  rsp_t       core_rsp_o;
  req_t       out_req_o;
  logic       sh_req_o;
  logic       sh_gnt_i;
  logic       sh_r_valid_i;
  data_t      sh_r_rdata_i;
  logic       ext_req_o;
  logic       ext_gnt_i;
  rsp_t       ext_rsp_i;
  logic       pe_req_o;
  logic       pe_gnt_i;
  rsp_t       pe_rsp_i;
  logic [3:0] perf;     // {ld, st, ld_cyc, st_cyc}
  int         errors;
  integer     seed;

  data_periph_demux #(
    .REMAP_ADDRESS      (1'b1),
    .CLUSTER_ALIAS      (1'b1),
    .CLUSTER_ALIAS_BASE (12'h000)
  ) u_data_periph_demux (
    .base_addr_i      (4'hA),
    .cluster_id_i     (6'd3),   // TCDM at regions 0x10C and 0x10D
    .perf_l2_ld_o     (perf[3]),
    .perf_l2_st_o     (perf[2]),
    .perf_l2_ld_cyc_o (perf[1]),
    .perf_l2_st_cyc_o (perf[0]),
    .*
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("Watchdog timeout after %0d cycles, errors: %0d", NUM_TESTS * CYCLES_PER_TEST,
             errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // ******************************
  // Helpers and target models
  // ******************************
  task automatic compare_value(input string test, input string what,
                               input logic [68:0] expected, input logic [68:0] actual);
    assert (actual === expected)
    else
    begin
      errors++;
      $display("[FAIL] %s %s: expected %0h, actual %0h", test, what, expected, actual);
    end
  endtask

  task automatic issue_req(input addr_t addr, input logic wen, output req_t r);
    r.addr          = addr;
    r.wen           = wen;
    r.wdata         = $random(seed);
    r.be            = $random(seed);
    core_req_i      <= 1'b1;
    core_req_data_i <= r;
  endtask

  task automatic release_req();
    core_req_i <= 1'b0;
    sh_gnt_i   <= 1'b0;
    ext_gnt_i  <= 1'b0;
    pe_gnt_i   <= 1'b0;
  endtask

  task automatic drive_response(input dest_e target, input logic vld, input data_t rd,
                                input logic opc);
    case (target)
      SH:
      begin
        sh_r_valid_i <= vld;
        sh_r_rdata_i <= rd;
      end
      EXT:     ext_rsp_i <= '{valid: vld, rdata: rd, opc: opc};
      default: pe_rsp_i  <= '{valid: vld, rdata: rd, opc: opc};
    endcase
  endtask

  task automatic check_route(input string test, input addr_t addr, input logic [2:0] exp_strb);
    req_t r;
    @(posedge clk);
    issue_req(addr, 1'b1, r);
    @(negedge clk);
    compare_value(test, "strobes", exp_strb, {sh_req_o, ext_req_o, pe_req_o});
    @(posedge clk);
    release_req();
  endtask

  // ******************************
  // Directed tests
  // ******************************
  task automatic test_sh_route();
    req_t  r;
    data_t rd;
    for (int i = 0; i < 2; i++)
    begin
      rd = $random(seed);
      @(posedge clk);
      issue_req(32'hA0C0_0040 + (i << 20), 1'b1, r);   // Region 0x10C, then 0x10D
      @(negedge clk);
      compare_value("test_sh_route", "strobes", 3'b100, {sh_req_o, ext_req_o, pe_req_o});
      compare_value("test_sh_route", "gnt held low", 1'b0, core_gnt_o);
      @(posedge clk);
      sh_gnt_i <= 1'b1;
      @(negedge clk);
      compare_value("test_sh_route", "gnt", 1'b1, core_gnt_o);
      @(posedge clk);
      release_req();
      drive_response(SH, 1'b1, rd, 1'b0);
      @(negedge clk);
      compare_value("test_sh_route", "rsp", {1'b1, rd, 1'b0}, core_rsp_o);
      @(posedge clk);
      drive_response(SH, 1'b0, '0, 1'b0);
    end
  endtask

  task automatic test_ext_route();
    req_t  r;
    data_t rd;
    logic  wen;
    for (int i = 0; i < 2; i++)
    begin
      wen = (i == 0);   // Load first, then store
      rd  = $random(seed);
      @(posedge clk);
      issue_req(32'hA0E0_4008, wen, r);
      @(negedge clk);
      compare_value("test_ext_route", "strobes", 3'b010, {sh_req_o, ext_req_o, pe_req_o});
      compare_value("test_ext_route", "gnt held low", 1'b0, core_gnt_o);
      compare_value("test_ext_route", "perf waiting", {2'b00, wen, ~wen}, perf);
      @(posedge clk);
      ext_gnt_i <= 1'b1;
      @(negedge clk);
      compare_value("test_ext_route", "gnt", 1'b1, core_gnt_o);
      compare_value("test_ext_route", "perf accepted", {wen, ~wen, wen, ~wen}, perf);
      @(posedge clk);
      release_req();
      drive_response(EXT, 1'b1, rd, ~wen);
      @(negedge clk);
      compare_value("test_ext_route", "perf idle", 4'b0000, perf);
      compare_value("test_ext_route", "rsp", {1'b1, rd, ~wen}, core_rsp_o);
      @(posedge clk);
      drive_response(EXT, 1'b0, '0, 1'b0);
    end
  endtask

  task automatic test_pe_txn();
    addr_t addrs [2];
    req_t  r;
    data_t rd;
    addrs[0] = 32'h2000_0100;   // Outside the cluster
    addrs[1] = 32'hA0E0_0010;   // Region 0x10E with bit 14 clear
    for (int i = 0; i < 2; i++)
    begin
      rd = $random(seed);
      @(posedge clk);
      issue_req(addrs[i], i[0], r);
      repeat (2)
      begin
        @(negedge clk);
        compare_value("test_pe_txn", "strobes", 3'b001, {sh_req_o, ext_req_o, pe_req_o});
        compare_value("test_pe_txn", "gnt waiting", 1'b0, core_gnt_o);
        @(posedge clk);
      end
      pe_gnt_i <= 1'b1;
      @(posedge clk);
      pe_gnt_i <= 1'b0;
      @(negedge clk);
      compare_value("test_pe_txn", "pe_req pending", 1'b0, pe_req_o);
      @(posedge clk);
      drive_response(PE, 1'b1, rd, i[0]);
      @(negedge clk);
      compare_value("test_pe_txn", "gnt at rsp", 1'b0, core_gnt_o);
      @(posedge clk);
      drive_response(PE, 1'b0, '0, 1'b0);
      @(negedge clk);
      compare_value("test_pe_txn", "gnt after rsp", 1'b1, core_gnt_o);
      compare_value("test_pe_txn", "rsp early", 1'b0, core_rsp_o.valid);
      @(posedge clk);
      release_req();
      @(negedge clk);
      compare_value("test_pe_txn", "rsp", {1'b1, rd, i[0]}, core_rsp_o);
      compare_value("test_pe_txn", "gnt done", 1'b0, core_gnt_o);
    end
  endtask

  task automatic test_remap();
    addr_t in_addr  [4];
    addr_t exp_addr [4];
    req_t  r;
    in_addr[0]  = 32'hA123_4567;
    exp_addr[0] = 32'h1123_4567;
    in_addr[1]  = 32'h1ABC_DEF0;
    exp_addr[1] = 32'hAABC_DEF0;
    in_addr[2]  = 32'h5555_1234;
    exp_addr[2] = 32'h5555_1234;
    in_addr[3]  = 32'hB000_0001;
    exp_addr[3] = 32'hB000_0001;
    for (int i = 0; i < 4; i++)
    begin
      @(posedge clk);
      issue_req(in_addr[i], i[0], r);
      @(negedge clk);
      compare_value("test_remap", "payload", {exp_addr[i], r.wen, r.wdata, r.be}, out_req_o);
      @(posedge clk);
      release_req();
    end
  endtask

  task automatic test_alias();
    check_route("test_alias", 32'h0000_1000, 3'b100);
    check_route("test_alias", 32'h0010_2000, 3'b100);
    check_route("test_alias", 32'h0020_4000, 3'b010);   // Bit 14 set
    check_route("test_alias", 32'h0020_0000, 3'b001);
  endtask

  initial
  begin
    errors          = 0;
    seed            = 58;
    rst_ni          = 1'b0;
    core_req_i      = 1'b0;
    core_req_data_i = '0;
    sh_gnt_i        = 1'b0;
    sh_r_valid_i    = 1'b0;
    sh_r_rdata_i    = '0;
    ext_gnt_i       = 1'b0;
    ext_rsp_i       = '0;
    pe_gnt_i        = 1'b0;
    pe_rsp_i        = '0;
    repeat (5) @(posedge clk);
    rst_ni <= 1'b1;
    test_sh_route();
    test_ext_route();
    test_pe_txn();
    test_remap();
    test_alias();
    @(posedge clk);
    errors += u_data_periph_demux.u_chk.fail_count;   // Bound port assertions
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule : tb_data_periph_demux

`default_nettype wire
